// File: filelist.f
+incdir+test
hw/read_engine_pkg.sv
hw/stride_counter.sv
hw/read_engine_control.sv
hw/request_fifo.sv
hw/read_engine_top.sv
test/tb_read_engine.sv

// File: Makefile
# Verilator build and run for the strided read-request engine

VERILATOR ?= verilator
TOP       ?= tb_read_engine
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SOURCES := $(wildcard hw/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: test/read_engine_model.svh
// Read engine reference model and checkers
// Expected request queue built from the range rules, typed compare
// tasks and bounded waits on the DUT status outputs

`ifndef READ_ENGINE_MODEL_SVH
`define READ_ENGINE_MODEL_SVH

// --------------------------------------------------
// Expected requests
// --------------------------------------------------
read_request_t expected_q[$];

// Walk the range the way the engine should, oldest request first
task automatic build_expected(input engine_config_t cfg);
    index_t        idx;
    addr_t         offset;
    read_request_t req;
    expected_q.delete();
    idx = cfg.start_read;
    while (idx < cfg.end_read) begin
        if (cfg.shift_left) begin
            offset = idx << cfg.shift_amount;
        end else begin
            offset = idx >> cfg.shift_amount;
        end
        req.address = cfg.array_pointer + offset;
        req.index   = idx;
        expected_q.push_back(req);
        idx = idx + cfg.stride;
    end
endtask

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------
task automatic check_request(input string name, input read_request_t got,
                             input read_request_t exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("Fail %s: got address %h index %h, expected address %h index %h",
                                    name, got.address, got.index, exp.address, exp.index));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
endtask

// Polls one cycle at a time until the engine is idle
task automatic wait_ready_out(input int max_cycles);
    int cycles;
    cycles = 0;
    @(posedge ap_clk);
    #DRIVE_DELAY;
    while (ready_out !== 1'b1) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            stop_with_failure("Timed out waiting for ready_out to rise");
        end
        @(posedge ap_clk);
        #DRIVE_DELAY;
    end
endtask

`endif

// File: test/tb_read_engine.sv
// Read engine testbench
// Random strided runs against a queue model, with consumer back-pressure,
// hold checks on stalled requests and the start/done handshake

`timescale 1ns/1ps

module tb_read_engine;

    import read_engine_pkg::*;

    localparam int DRIVE_DELAY  = 2;
    localparam int READY_LIMIT  = 50;
    localparam int RUN_LIMIT    = 20000;

    logic           ap_clk;
    logic           areset_engine;
    engine_config_t config_in;
    logic           config_valid;
    logic           start_in;
    logic           request_ready;
    read_request_t  request_out;
    logic           request_valid;
    logic           ready_out;
    logic           done_out;

    logic [31:0]    rng_state;

    read_engine_top read_engine_top_inst (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .config_in     (config_in),
        .config_valid  (config_valid),
        .start_in      (start_in),
        .request_ready (request_ready),
        .request_out   (request_out),
        .request_valid (request_valid),
        .ready_out     (ready_out),
        .done_out      (done_out)
    );

    always #20 ap_clk = ~ap_clk;

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    `include "read_engine_model.svh"

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Short runs low in the index space with a nonzero stride
    function automatic engine_config_t random_config(input logic shift_left);
        engine_config_t cfg;
        cfg.array_pointer = next_random();
        cfg.start_read    = next_random() % 1000;
        cfg.stride        = (next_random() % 7) + 1;
        cfg.end_read      = cfg.start_read + (next_random() % 120) + 1;
        cfg.shift_left    = shift_left;
        cfg.shift_amount  = shift_amt_t'(next_random() % 32);
        return cfg;
    endfunction

    // One complete run from the start handshake back to idle
    task automatic run_config(input engine_config_t cfg, input logic random_ready);
        read_request_t held;
        logic          holding;
        logic          ready;
        logic [31:0]   r;
        int            stall_left;
        int            cycles;
        build_expected(cfg);
        config_in    = cfg;
        config_valid = 1'b1;
        start_in     = 1'b1;
        @(posedge ap_clk);
        #DRIVE_DELAY;
        // Captured config must survive junk on the input
        config_valid = 1'b0;
        config_in    = random_config(~cfg.shift_left);
        holding      = 1'b0;
        stall_left   = 0;
        cycles       = 0;
        while (!(done_out === 1'b1 && expected_q.size() == 0)) begin
            if (expected_q.size() != 0) begin
                check_flag("done_out", done_out, 1'b0);
            end
            if (holding) begin
                check_flag("request_valid", request_valid, 1'b1);
                check_request("request_out", request_out, held);
            end
            if (!random_ready) begin
                ready = 1'b1;
            end else if (stall_left > 0) begin
                ready      = 1'b0;
                stall_left = stall_left - 1;
            end else begin
                r = next_random();
                // Long stalls push the FIFO past its threshold
                if (r[4:2] == 3'd0) begin
                    stall_left = 12 + int'(r[11:8]);
                    ready      = 1'b0;
                end else begin
                    ready = r[16];
                end
            end
            request_ready = ready;
            if (request_valid === 1'b1 && ready) begin
                if (expected_q.size() == 0) begin
                    stop_with_failure("A request transferred beyond the expected sequence");
                end
                check_request("request_out", request_out, expected_q.pop_front());
            end
            holding = (request_valid === 1'b1) && !ready;
            held    = request_out;
            cycles  = cycles + 1;
            if (cycles >= RUN_LIMIT) begin
                stop_with_failure("Timed out waiting for done_out at the end of a run");
            end
            @(posedge ap_clk);
            #DRIVE_DELAY;
        end
        request_ready = 1'b0;
        // Engine must stay in DONE while start is held
        check_flag("ready_out", ready_out, 1'b0);
        @(posedge ap_clk);
        #DRIVE_DELAY;
        check_flag("ready_out", ready_out, 1'b0);
        check_flag("done_out", done_out, 1'b1);
        start_in = 1'b0;
        wait_ready_out(READY_LIMIT);
        check_flag("done_out", done_out, 1'b0);
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        engine_config_t cfg;
        ap_clk        = 1'b0;
        areset_engine = 1'b1;
        config_in     = '0;
        config_valid  = 1'b0;
        start_in      = 1'b0;
        request_ready = 1'b0;
        rng_state     = 32'd81483;

        repeat (2) @(posedge ap_clk);
        #DRIVE_DELAY;
        check_flag("request_valid", request_valid, 1'b0);
        check_flag("done_out", done_out, 1'b0);
        check_flag("ready_out", ready_out, 1'b0);
        areset_engine = 1'b0;
        wait_ready_out(READY_LIMIT);

        // Left shift with the consumer always ready
        for (int i = 0; i < 3; i++) begin
            run_config(random_config(1'b1), 1'b0);
        end
        // Right shift under random back-pressure
        for (int i = 0; i < 4; i++) begin
            run_config(random_config(1'b0), 1'b1);
        end

        // Empty ranges
        cfg = random_config(1'b0);
        cfg.end_read = cfg.start_read;
        run_config(cfg, 1'b1);
        cfg = random_config(1'b1);
        cfg.start_read = cfg.start_read + 8;
        cfg.end_read   = cfg.start_read - 3;
        run_config(cfg, 1'b0);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule : tb_read_engine

// File: hw/read_engine_top.sv
// Strided read-request engine
// Walks an index range by a stride and queues one shifted-address
// read request per index for a valid/ready consumer

`timescale 1ns/1ps

module read_engine_top #(
    parameter int FIFO_DEPTH  = 16,
    // Also sets the pause point of the control FSM. Depth minus
    // threshold must cover the two requests in flight
    parameter int PROG_THRESH = 8
) (
    input  logic                           ap_clk,
    input  logic                           areset_engine,
    input  read_engine_pkg::engine_config_t config_in,
    input  logic                           config_valid,
    input  logic                           start_in,
    input  logic                           request_ready,
    output read_engine_pkg::read_request_t request_out,
    output logic                           request_valid,
    output logic                           ready_out,
    output logic                           done_out
);

    import read_engine_pkg::*;

    // --------------------------------------------------
    // Internal wiring
    // --------------------------------------------------
    logic          load;
    logic          advance;
    index_t        load_value;
    index_t        stride;
    index_t        count;

    logic          push;
    read_request_t push_data;
    logic          prog_full;
    logic          fifo_empty;

    read_engine_control read_engine_control_inst (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .config_in     (config_in),
        .config_valid  (config_valid),
        .start_in      (start_in),
        .count         (count),
        .prog_full     (prog_full),
        .fifo_empty    (fifo_empty),
        .load          (load),
        .advance       (advance),
        .load_value    (load_value),
        .stride        (stride),
        .push          (push),
        .push_data     (push_data),
        .ready_out     (ready_out),
        .done_out      (done_out)
    );

    stride_counter stride_counter_inst (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .load          (load),
        .advance       (advance),
        .load_value    (load_value),
        .stride        (stride),
        .count         (count)
    );

    // Request queue toward the memory side
    request_fifo #(
        .FIFO_DEPTH    (FIFO_DEPTH),
        .PROG_THRESH   (PROG_THRESH)
    ) request_fifo_inst (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .push          (push),
        .push_data     (push_data),
        .request_ready (request_ready),
        .request_out   (request_out),
        .request_valid (request_valid),
        .prog_full     (prog_full),
        .empty         (fifo_empty)
    );

endmodule : read_engine_top

// File: hw/request_fifo.sv
// Request FIFO
// Synchronous circular queue of read requests with a level count,
// programmable-full flag and a valid/ready read port

`timescale 1ns/1ps

module request_fifo #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                           ap_clk,
    input  logic                           areset_engine,
    input  logic                           push,
    input  read_engine_pkg::read_request_t push_data,
    input  logic                           request_ready,
    output read_engine_pkg::read_request_t request_out,
    output logic                           request_valid,
    output logic                           prog_full,
    output logic                           empty
);

    import read_engine_pkg::*;

    localparam int PTR_WIDTH   = $clog2(FIFO_DEPTH);
    localparam int LEVEL_WIDTH = $clog2(FIFO_DEPTH + 1);

    // --------------------------------------------------
    // Storage and pointers
    // --------------------------------------------------
    read_request_t          mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [LEVEL_WIDTH-1:0] level;

    logic full;
    logic wr_en;
    logic rd_en;

    assign empty = (level == '0);
    assign full  = (level == LEVEL_WIDTH'(FIFO_DEPTH));

    // Pushes into a full queue are dropped
    assign wr_en = push && !full;
    assign rd_en = request_valid && request_ready;

    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Level
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            level <= '0;
        end else if (wr_en && !rd_en) begin
            level <= level + 1'b1;
        end else if (rd_en && !wr_en) begin
            level <= level - 1'b1;
        end
    end

    assign prog_full = (level >= LEVEL_WIDTH'(PROG_THRESH));

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------
    // Head entry is shown directly and stays put until popped
    assign request_out   = mem[rd_ptr];
    assign request_valid = !empty;

endmodule : request_fifo

// File: hw/read_engine_control.sv
// Read engine control
// Sequences a run: captures the configuration, drives the stride counter,
// tests the index against end_read and forms registered FIFO pushes

`timescale 1ns/1ps

module read_engine_control (
    input  logic                           ap_clk,
    input  logic                           areset_engine,
    input  read_engine_pkg::engine_config_t config_in,
    input  logic                           config_valid,
    input  logic                           start_in,
    input  read_engine_pkg::index_t        count,
    input  logic                           prog_full,
    input  logic                           fifo_empty,
    output logic                           load,
    output logic                           advance,
    output read_engine_pkg::index_t        load_value,
    output read_engine_pkg::index_t        stride,
    output logic                           push,
    output read_engine_pkg::read_request_t push_data,
    output logic                           ready_out,
    output logic                           done_out
);

    import read_engine_pkg::*;

    // --------------------------------------------------
    // Signals
    // --------------------------------------------------
    engine_state_t  state;
    engine_state_t  next_state;

    // Configuration held for the whole run
    engine_config_t cfg_reg;

    logic           start_run;
    logic           in_range;
    logic           gen;
    addr_t          offset;
    read_request_t  request_next;

    // Handshake with software
    assign start_run = (state == IDLE) && config_valid && start_in;

    // End-of-range test
    assign in_range = (count < cfg_reg.end_read);

    // One request per cycle in BUSY, held off by a full FIFO
    assign gen = (state == BUSY) && in_range && !prog_full;

    // --------------------------------------------------
    // State register
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET: begin
                next_state = IDLE;
            end
            IDLE: begin
                if (start_run) begin
                    next_state = SETUP;
                end
            end
            // Counter is loaded on the way out
            SETUP: begin
                next_state = BUSY;
            end
            BUSY: begin
                if (!in_range) begin
                    next_state = DONE;
                end else if (prog_full) begin
                    next_state = PAUSE;
                end
            end
            PAUSE: begin
                if (!prog_full) begin
                    next_state = BUSY;
                end
            end
            DONE: begin
                if (!start_in) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = RESET;
            end
        endcase
    end

    // --------------------------------------------------
    // Configuration capture
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (start_run) begin
            cfg_reg <= config_in;
        end
    end

    // --------------------------------------------------
    // Counter control
    // --------------------------------------------------
    assign load       = (state == SETUP);
    assign advance    = gen;
    assign load_value = cfg_reg.start_read;
    assign stride     = cfg_reg.stride;

    // --------------------------------------------------
    // Request formation
    // --------------------------------------------------
    always_comb begin
        if (cfg_reg.shift_left) begin
            offset = addr_t'(count) << cfg_reg.shift_amount;
        end else begin
            offset = addr_t'(count) >> cfg_reg.shift_amount;
        end
    end

    assign request_next.address = cfg_reg.array_pointer + offset;
    assign request_next.index   = count;

    // Push stage, one cycle behind the counter
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            push <= 1'b0;
        end else begin
            push <= gen;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (gen) begin
            push_data <= request_next;
        end
    end

    // --------------------------------------------------
    // Status to software
    // --------------------------------------------------
    assign ready_out = (state == IDLE);

    // Walk finished and every request drained
    assign done_out = (state == DONE) && fifo_empty;

endmodule : read_engine_control

// File: hw/stride_counter.sv
// Stride counter
// Holds the current walk index. Loads a start value and
// steps forward by a held stride on request

`timescale 1ns/1ps

module stride_counter (
    input  logic                    ap_clk,
    input  logic                    areset_engine,
    input  logic                    load,
    input  logic                    advance,
    input  read_engine_pkg::index_t load_value,
    input  read_engine_pkg::index_t stride,
    output read_engine_pkg::index_t count
);

    // --------------------------------------------------
    // Walk position
    // --------------------------------------------------
    // Load wins over advance so a new run always
    // starts from a clean position
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;
        end else if (advance) begin
            // Wraps silently past the top of the index range
            count <= count + stride;
        end
    end

endmodule : stride_counter

// File: hw/read_engine_pkg.sv
// Read engine package
// Widths, configuration and request structs, and the control FSM states
// shared by the strided read-request engine

package read_engine_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int INDEX_WIDTH = 32;
    localparam int ADDR_WIDTH  = 32;
    localparam int SHIFT_WIDTH = 5;

    // --------------------------------------------------
    // Plain vector types
    // --------------------------------------------------
    // Element index, also used for range bounds and stride
    typedef logic [INDEX_WIDTH-1:0] index_t;

    // Byte address in memory
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Shift applied to the index when forming the address
    typedef logic [SHIFT_WIDTH-1:0] shift_amt_t;

    // --------------------------------------------------
    // Configuration and request
    // --------------------------------------------------
    // Software view of one run, 134 bits
    typedef struct packed {
        addr_t      array_pointer;
        index_t     start_read;
        index_t     end_read;
        index_t     stride;
        // 1 shifts left, 0 shifts right
        logic       shift_left;
        shift_amt_t shift_amount;
    } engine_config_t;

    // One memory read request
    // Index rides along as the data tag
    typedef struct packed {
        addr_t  address;
        index_t index;
    } read_request_t;

    // --------------------------------------------------
    // Control FSM
    // --------------------------------------------------
    typedef enum logic [2:0] {
        RESET,
        IDLE,
        SETUP,
        BUSY,
        PAUSE,
        DONE
    } engine_state_t;

endpackage : read_engine_pkg
